// File: logic/csr_pkg.sv
package csr_pkg;

    localparam int XLEN      = 32;
    localparam int CSR_NUM_W = 14;

    // Register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    // Exception code fields in ESTAT
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    localparam int PLV_W = 2;

    // Interrupt status holds swi at 1:0, hwi at 9:2, timer at 11 and ipi at 12
    localparam int INT_W         = 13;
    localparam int TIMER_INT_BIT = 11;
    localparam int HW_INT_W      = 8;

    // Entry address is aligned to 64 bytes
    localparam int EENTRY_VA_LSB = 6;

    localparam int TCFG_INITV_W = 30;

    function automatic logic [XLEN-1:0] masked_merge(
        input logic [XLEN-1:0] old_value,
        input logic [XLEN-1:0] new_value,
        input logic [XLEN-1:0] mask
    );
        return (new_value & mask) | (old_value & ~mask);
    endfunction

endpackage

// File: logic/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode (
    input  logic [csr_pkg::CSR_NUM_W-1:0]                     csr_num,
    input  logic                                              csr_we,
    input  logic [csr_pkg::XLEN-1:0]                          crmd_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          prmd_rvalue,
    input  logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0]   estat_code_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          era_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          eentry_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          save_rvalue,
    input  logic [csr_pkg::INT_W-1:0]                         is_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          ecfg_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          tcfg_rvalue,
    input  logic [csr_pkg::XLEN-1:0]                          tval_rvalue,
    output logic                                              we_crmd,
    output logic                                              we_prmd,
    output logic                                              we_estat,
    output logic                                              we_era,
    output logic                                              we_eentry,
    output logic                                              we_save,
    output logic                                              we_ecfg,
    output logic                                              we_tcfg,
    output logic                                              we_ticlr,
    output logic [csr_pkg::XLEN-1:0]                          csr_rvalue
);

    logic [csr_pkg::XLEN-1:0] estat_rvalue;

    assign we_crmd   = csr_we && (csr_num == csr_pkg::CSR_CRMD);
    assign we_prmd   = csr_we && (csr_num == csr_pkg::CSR_PRMD);
    assign we_estat  = csr_we && (csr_num == csr_pkg::CSR_ESTAT);
    assign we_era    = csr_we && (csr_num == csr_pkg::CSR_ERA);
    assign we_eentry = csr_we && (csr_num == csr_pkg::CSR_EENTRY);
    assign we_ecfg   = csr_we && (csr_num == csr_pkg::CSR_ECFG);
    assign we_tcfg   = csr_we && (csr_num == csr_pkg::CSR_TCFG);
    assign we_ticlr  = csr_we && (csr_num == csr_pkg::CSR_TICLR);

    // SAVE0..3 share one strobe and the low bits pick the word
    assign we_save = csr_we &&
        (csr_num[csr_pkg::CSR_NUM_W-1:2] == csr_pkg::CSR_SAVE0[csr_pkg::CSR_NUM_W-1:2]);

    // Codes at 30:16 and interrupt status at 12:0
    assign estat_rvalue = {1'b0, estat_code_rvalue, 3'b0, is_rvalue};

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   csr_rvalue = crmd_rvalue;
            csr_pkg::CSR_PRMD:   csr_rvalue = prmd_rvalue;
            csr_pkg::CSR_ECFG:   csr_rvalue = ecfg_rvalue;
            csr_pkg::CSR_ESTAT:  csr_rvalue = estat_rvalue;
            csr_pkg::CSR_ERA:    csr_rvalue = era_rvalue;
            csr_pkg::CSR_EENTRY: csr_rvalue = eentry_rvalue;
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  csr_rvalue = save_rvalue;
            csr_pkg::CSR_TCFG:   csr_rvalue = tcfg_rvalue;
            csr_pkg::CSR_TVAL:   csr_rvalue = tval_rvalue;
            default:             csr_rvalue = '0;
        endcase
    end

endmodule

// File: logic/csr_exception_regs.sv
`timescale 1ns/1ps

module csr_exception_regs (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              we_crmd,
    input  logic                                              we_prmd,
    input  logic                                              we_estat,
    input  logic                                              we_era,
    input  logic                                              we_eentry,
    input  logic                                              we_save,
    input  logic [1:0]                                        save_sel,
    input  logic [csr_pkg::XLEN-1:0]                          csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]                          csr_wvalue,
    input  logic                                              wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]                       wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]                    wb_esubcode,
    input  logic [csr_pkg::XLEN-1:0]                          wb_pc,
    input  logic                                              ertn_flush,
    output logic                                              crmd_ie,
    output logic [csr_pkg::XLEN-1:0]                          crmd_rvalue,
    output logic [csr_pkg::XLEN-1:0]                          prmd_rvalue,
    output logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0]   estat_code_rvalue,
    output logic [csr_pkg::XLEN-1:0]                          era_rvalue,
    output logic [csr_pkg::XLEN-1:0]                          eentry_rvalue,
    output logic [csr_pkg::XLEN-1:0]                          save_rvalue,
    output logic [csr_pkg::XLEN-1:0]                          ex_entry,
    output logic [csr_pkg::XLEN-1:0]                          ertn_entry
);

    localparam int PAD_W  = csr_pkg::XLEN - csr_pkg::PLV_W - 1;
    localparam int CODE_W = csr_pkg::ECODE_W + csr_pkg::ESUBCODE_W;

    logic [csr_pkg::PLV_W-1:0]                    crmd_plv;
    logic [csr_pkg::PLV_W-1:0]                    prmd_pplv;
    logic                                         prmd_pie;
    logic [CODE_W-1:0]                            estat_code;
    logic [csr_pkg::XLEN-1:0]                     era;
    logic [csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB] eentry_va;
    logic [csr_pkg::XLEN-1:0]                     save [4];
    logic [csr_pkg::XLEN-1:0]                     crmd_next;
    logic [csr_pkg::XLEN-1:0]                     prmd_next;
    logic [csr_pkg::XLEN-1:0]                     estat_next;
    logic [csr_pkg::XLEN-1:0]                     eentry_next;

    assign crmd_rvalue       = {{PAD_W{1'b0}}, crmd_ie, crmd_plv};
    assign prmd_rvalue       = {{PAD_W{1'b0}}, prmd_pie, prmd_pplv};
    assign estat_code_rvalue = estat_code;
    assign era_rvalue        = era;
    assign eentry_rvalue     = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
    assign save_rvalue       = save[save_sel];
    assign ex_entry          = eentry_rvalue;
    assign ertn_entry        = era;

    assign crmd_next   = csr_pkg::masked_merge(crmd_rvalue, csr_wvalue, csr_wmask);
    assign prmd_next   = csr_pkg::masked_merge(prmd_rvalue, csr_wvalue, csr_wmask);
    assign eentry_next = csr_pkg::masked_merge(eentry_rvalue, csr_wvalue, csr_wmask);
    // Codes sit at ESTAT bits 30:16
    assign estat_next  = csr_pkg::masked_merge({1'b0, estat_code, 16'b0}, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv   <= '0;
            crmd_ie    <= 1'b0;
            prmd_pplv  <= '0;
            prmd_pie   <= 1'b0;
            estat_code <= '0;
            era        <= '0;
            eentry_va  <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else begin
            if (wb_ex) begin
                crmd_plv   <= '0;
                crmd_ie    <= 1'b0;
                prmd_pplv  <= crmd_plv;
                prmd_pie   <= crmd_ie;
                estat_code <= {wb_esubcode, wb_ecode};
                era        <= wb_pc;
            end else begin
                // Return restores the pre-exception mode
                if (ertn_flush) begin
                    crmd_plv <= prmd_pplv;
                    crmd_ie  <= prmd_pie;
                end else if (we_crmd) begin
                    crmd_plv <= crmd_next[csr_pkg::PLV_W-1:0];
                    crmd_ie  <= crmd_next[csr_pkg::PLV_W];
                end
                if (we_prmd) begin
                    prmd_pplv <= prmd_next[csr_pkg::PLV_W-1:0];
                    prmd_pie  <= prmd_next[csr_pkg::PLV_W];
                end
                if (we_estat) begin
                    estat_code <= estat_next[30:16];
                end
                if (we_era) begin
                    era <= csr_pkg::masked_merge(era, csr_wvalue, csr_wmask);
                end
            end
            if (we_eentry) begin
                eentry_va <= eentry_next[csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB];
            end
            if (we_save) begin
                save[save_sel] <= csr_pkg::masked_merge(save[save_sel], csr_wvalue, csr_wmask);
            end
        end
    end

endmodule

// File: logic/csr_interrupt.sv
`timescale 1ns/1ps

module csr_interrupt (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we_estat,
    input  logic                           we_ecfg,
    input  logic                           we_ticlr,
    input  logic [csr_pkg::XLEN-1:0]       csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]       csr_wvalue,
    input  logic [csr_pkg::HW_INT_W-1:0]   hw_int_in,
    input  logic                           ipi_int_in,
    input  logic                           timer_fire,
    input  logic                           crmd_ie,
    output logic [csr_pkg::INT_W-1:0]      is_rvalue,
    output logic [csr_pkg::XLEN-1:0]       ecfg_rvalue,
    output logic                           has_int
);

    localparam int PAD_W = csr_pkg::XLEN - csr_pkg::INT_W;

    logic [1:0]                     is_swi;
    logic [csr_pkg::HW_INT_W-1:0]   is_hwi;
    logic                           is_ti;
    logic                           is_ipi;
    logic [csr_pkg::INT_W-1:0]      ecfg_lie;
    logic [csr_pkg::XLEN-1:0]       estat_next;
    logic [csr_pkg::XLEN-1:0]       ecfg_next;
    logic                           ticlr;

    always_comb begin
        is_rvalue = '0;
        is_rvalue[1:0] = is_swi;
        is_rvalue[9:2] = is_hwi;
        is_rvalue[csr_pkg::TIMER_INT_BIT] = is_ti;
        is_rvalue[12] = is_ipi;
    end

    assign estat_next  = csr_pkg::masked_merge({{PAD_W{1'b0}}, is_rvalue}, csr_wvalue, csr_wmask);
    assign ecfg_next   = csr_pkg::masked_merge(ecfg_rvalue, csr_wvalue, csr_wmask);
    assign ticlr       = we_ticlr && csr_wmask[0] && csr_wvalue[0];
    assign ecfg_rvalue = {{PAD_W{1'b0}}, ecfg_lie};

    always_ff @(posedge clk) begin
        if (reset) begin
            is_swi   <= '0;
            is_hwi   <= '0;
            is_ti    <= 1'b0;
            is_ipi   <= 1'b0;
            ecfg_lie <= '0;
        end else begin
            is_hwi <= hw_int_in;
            is_ipi <= ipi_int_in;
            if (we_estat) begin
                is_swi <= estat_next[1:0];
            end
            // A new timer event wins over a clear in the same cycle
            if (timer_fire) begin
                is_ti <= 1'b1;
            end else if (ticlr) begin
                is_ti <= 1'b0;
            end
            if (we_ecfg) begin
                ecfg_lie <= {ecfg_next[12:11], 1'b0, ecfg_next[9:0]};
            end
        end
    end

    assign has_int = ((is_rvalue[11:0] & ecfg_lie[11:0]) != 12'b0) && crmd_ie;

endmodule

// File: logic/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we_tcfg,
    input  logic [csr_pkg::XLEN-1:0]   csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]   csr_wvalue,
    output logic [csr_pkg::XLEN-1:0]   tcfg_rvalue,
    output logic [csr_pkg::XLEN-1:0]   tval_rvalue,
    output logic                       timer_fire
);

    logic                               tcfg_en;
    logic                               tcfg_periodic;
    logic [csr_pkg::TCFG_INITV_W-1:0]   tcfg_initv;
    logic [csr_pkg::XLEN-1:0]           tcfg_next;
    logic [csr_pkg::XLEN-1:0]           timer_cnt;

    assign tcfg_rvalue = {tcfg_initv, tcfg_periodic, tcfg_en};
    assign tcfg_next   = csr_pkg::masked_merge(tcfg_rvalue, csr_wvalue, csr_wmask);
    assign tval_rvalue = timer_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initv    <= '0;
        end else if (we_tcfg) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initv    <= tcfg_next[csr_pkg::XLEN-1:2];
        end
    end

    // All ones means stopped after a one-shot expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (we_tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[csr_pkg::XLEN-1:2], 2'b0};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initv, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    assign timer_fire = tcfg_en && (timer_cnt == '0);

endmodule

// File: logic/csr_file_top.sv
`timescale 1ns/1ps

module csr_file_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [csr_pkg::CSR_NUM_W-1:0]      csr_num,
    input  logic                               csr_we,
    input  logic [csr_pkg::XLEN-1:0]           csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]           csr_wvalue,
    input  logic                               wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]        wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]     wb_esubcode,
    input  logic [csr_pkg::XLEN-1:0]           wb_pc,
    input  logic                               ertn_flush,
    input  logic [csr_pkg::HW_INT_W-1:0]       hw_int_in,
    input  logic                               ipi_int_in,
    output logic [csr_pkg::XLEN-1:0]           csr_rvalue,
    output logic [csr_pkg::XLEN-1:0]           ex_entry,
    output logic [csr_pkg::XLEN-1:0]           ertn_entry,
    output logic                               has_int
);

    logic we_crmd, we_prmd, we_estat, we_era, we_eentry;
    logic we_save, we_ecfg, we_tcfg, we_ticlr;
    logic crmd_ie;
    logic timer_fire;
    logic [csr_pkg::XLEN-1:0]                          crmd_rvalue;
    logic [csr_pkg::XLEN-1:0]                          prmd_rvalue;
    logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0]   estat_code_rvalue;
    logic [csr_pkg::XLEN-1:0]                          era_rvalue;
    logic [csr_pkg::XLEN-1:0]                          eentry_rvalue;
    logic [csr_pkg::XLEN-1:0]                          save_rvalue;
    logic [csr_pkg::INT_W-1:0]                         is_rvalue;
    logic [csr_pkg::XLEN-1:0]                          ecfg_rvalue;
    logic [csr_pkg::XLEN-1:0]                          tcfg_rvalue;
    logic [csr_pkg::XLEN-1:0]                          tval_rvalue;

    csr_access_decode csr_access_decode_i (
        .csr_num, .csr_we,
        .crmd_rvalue, .prmd_rvalue, .estat_code_rvalue, .era_rvalue, .eentry_rvalue,
        .save_rvalue, .is_rvalue, .ecfg_rvalue, .tcfg_rvalue, .tval_rvalue,
        .we_crmd, .we_prmd, .we_estat, .we_era, .we_eentry,
        .we_save, .we_ecfg, .we_tcfg, .we_ticlr,
        .csr_rvalue
    );

    csr_exception_regs csr_exception_regs_i (
        .clk, .reset,
        .we_crmd, .we_prmd, .we_estat, .we_era, .we_eentry, .we_save,
        .save_sel   (csr_num[1:0]),
        .csr_wmask, .csr_wvalue,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .ertn_flush,
        .crmd_ie, .crmd_rvalue, .prmd_rvalue, .estat_code_rvalue,
        .era_rvalue, .eentry_rvalue, .save_rvalue, .ex_entry, .ertn_entry
    );

    csr_interrupt csr_interrupt_i (
        .clk, .reset,
        .we_estat, .we_ecfg, .we_ticlr, .csr_wmask, .csr_wvalue,
        .hw_int_in, .ipi_int_in, .timer_fire, .crmd_ie,
        .is_rvalue, .ecfg_rvalue, .has_int
    );

    csr_timer csr_timer_i (
        .clk, .reset,
        .we_tcfg, .csr_wmask, .csr_wvalue,
        .tcfg_rvalue, .tval_rvalue, .timer_fire
    );

endmodule

// File: tb/csr_file_checker.sv
`timescale 1ns/1ps

module csr_file_checker (
    input logic                             clk,
    input logic                             reset,
    input logic [csr_pkg::CSR_NUM_W-1:0]    csr_num,
    input logic [csr_pkg::XLEN-1:0]         csr_rvalue,
    input logic [csr_pkg::HW_INT_W-1:0]     hw_int_in,
    input logic                             wb_ex,
    input logic [csr_pkg::XLEN-1:0]         wb_pc,
    input logic                             ertn_flush,
    input logic [csr_pkg::XLEN-1:0]         ertn_entry,
    input logic [csr_pkg::XLEN-1:0]         ex_entry,
    input logic                             has_int,
    input logic [csr_pkg::XLEN-1:0]         crmd_rvalue,
    input logic [csr_pkg::XLEN-1:0]         prmd_rvalue,
    input logic [csr_pkg::XLEN-1:0]         ecfg_rvalue,
    input logic [csr_pkg::INT_W-1:0]        is_rvalue
);

    int assert_fails = 0;

    // Mode cleared and return address captured
    entry_state: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> (ertn_entry == $past(wb_pc)) && (crmd_rvalue[2:0] == 3'b0))
        else begin
            assert_fails++;
            $error("exception entry did not clear CRMD or capture the return address");
        end

    saved_mode: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> prmd_rvalue[2:0] == $past(crmd_rvalue[2:0]))
        else begin
            assert_fails++;
            $error("PRMD does not hold the mode from before the exception");
        end

    return_mode: assert property (@(posedge clk) disable iff (reset)
        ertn_flush |=> crmd_rvalue[2:0] == $past(prmd_rvalue[2:0]))
        else begin
            assert_fails++;
            $error("exception return did not restore CRMD from PRMD");
        end

    // EENTRY as read through the access port
    entry_address: assert property (@(posedge clk) disable iff (reset)
        (csr_num == csr_pkg::CSR_EENTRY) |-> (ex_entry == csr_rvalue))
        else begin
            assert_fails++;
            $error("ex_entry differs from EENTRY");
        end

    // Hardware bits are the hw_int_in sample of the previous edge
    int_request: assert property (@(posedge clk) disable iff (reset)
        has_int == ((({is_rvalue[11:10], $past(hw_int_in), is_rvalue[1:0]}
                      & ecfg_rvalue[11:0]) != 12'b0)
                    && crmd_rvalue[csr_pkg::PLV_W]))
        else begin
            assert_fails++;
            $error("has_int does not match enabled status and CRMD.IE");
        end

    // Enable bit 10 has no interrupt behind it
    reserved_enable: assert property (@(posedge clk) disable iff (reset)
        (csr_num == csr_pkg::CSR_ECFG) |-> (csr_rvalue[10] == 1'b0))
        else begin
            assert_fails++;
            $error("ECFG bit 10 reads one");
        end

endmodule

bind csr_file_top csr_file_checker checker_i (
    .clk           (clk),
    .reset         (reset),
    .csr_num       (csr_num),
    .csr_rvalue    (csr_rvalue),
    .hw_int_in     (hw_int_in),
    .wb_ex         (wb_ex),
    .wb_pc         (wb_pc),
    .ertn_flush    (ertn_flush),
    .ertn_entry    (ertn_entry),
    .ex_entry      (ex_entry),
    .has_int       (has_int),
    .crmd_rvalue   (crmd_rvalue),
    .prmd_rvalue   (prmd_rvalue),
    .ecfg_rvalue   (ecfg_rvalue),
    .is_rvalue     (is_rvalue)
);

// File: tb/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;

    localparam int CLK_PERIOD = 4;
    localparam int TIMER_N    = 3;
    // Cycle budget of each test, reset first
    localparam int BUDGET_CYCLES = 16 + 60 + 30 + 30 + (4 * TIMER_N + 40) + 160;
    localparam int WATCHDOG_NS   = (BUDGET_CYCLES + 100) * CLK_PERIOD;

    logic                               clk = 1'b0;
    logic                               reset;
    logic [csr_pkg::CSR_NUM_W-1:0]      csr_num;
    logic                               csr_we;
    logic [csr_pkg::XLEN-1:0]           csr_wmask;
    logic [csr_pkg::XLEN-1:0]           csr_wvalue;
    logic                               wb_ex;
    logic [csr_pkg::ECODE_W-1:0]        wb_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]     wb_esubcode;
    logic [csr_pkg::XLEN-1:0]           wb_pc;
    logic                               ertn_flush;
    logic [csr_pkg::HW_INT_W-1:0]       hw_int_in;
    logic                               ipi_int_in;
    logic [csr_pkg::XLEN-1:0]           csr_rvalue;
    logic [csr_pkg::XLEN-1:0]           ex_entry;
    logic [csr_pkg::XLEN-1:0]           ertn_entry;
    logic                               has_int;

    int                                 errors = 0;
    int                                 test_errors = 0;
    int                                 tests_failed = 0;
    int                                 checker_seen = 0;
    logic [csr_pkg::XLEN-1:0]           save_model [4];
    logic [csr_pkg::XLEN-1:0]           eentry_model;
    logic [csr_pkg::XLEN-1:0]           mask;
    logic [csr_pkg::XLEN-1:0]           data;
    logic [csr_pkg::XLEN-1:0]           pc;
    logic [csr_pkg::XLEN-1:0]           estat_codes;
    logic [csr_pkg::ECODE_W-1:0]        ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]     esub;
    logic [2:0]                         pick;

    csr_file_top csr_file_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    task automatic write_csr(input logic [csr_pkg::CSR_NUM_W-1:0] num,
                             input logic [csr_pkg::XLEN-1:0] wmask,
                             input logic [csr_pkg::XLEN-1:0] wvalue);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= 1'b1;
        csr_wmask  <= wmask;
        csr_wvalue <= wvalue;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic expect_csr(input logic [csr_pkg::CSR_NUM_W-1:0] num,
                              input logic [csr_pkg::XLEN-1:0] expected,
                              input string what);
        logic [csr_pkg::XLEN-1:0] got;
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        got = csr_rvalue;
        assert (got == expected) else begin
            $display("ERROR %0t: %s read %h, expected %h", $time, what, got, expected);
            test_errors++;
        end
    endtask

    // Optional CRMD write in the same cycle as the exception
    task automatic raise_exception(input logic with_crmd_write);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_pc       <= pc;
        wb_ecode    <= ecode;
        wb_esubcode <= esub;
        csr_num     <= csr_pkg::CSR_CRMD;
        csr_we      <= with_crmd_write;
        csr_wmask   <= 32'h7;
        csr_wvalue  <= 32'h7;
        @(posedge clk);
        wb_ex  <= 1'b0;
        csr_we <= 1'b0;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic finish_test(input int number, input string name);
        @(negedge clk);
        test_errors += csr_file_top_i.checker_i.assert_fails - checker_seen;
        checker_seen = csr_file_top_i.checker_i.assert_fails;
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", number, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", number, name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(32'h1a50cf74));
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        eentry_model = '0;
        for (int i = 0; i < 4; i++) begin
            save_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        assert (has_int == 1'b0) else begin
            $display("ERROR %0t: has_int high after reset", $time);
            test_errors++;
        end
        expect_csr(csr_pkg::CSR_CRMD, '0, "CRMD after reset");
        repeat (12) begin
            pick = 3'($urandom_range(4, 0));
            mask = $urandom;
            data = $urandom;
            if (pick == 3'd4) begin
                write_csr(csr_pkg::CSR_EENTRY, mask, data);
                eentry_model = ((data & mask) | (eentry_model & ~mask)) & ~32'h3f;
                expect_csr(csr_pkg::CSR_EENTRY, eentry_model, "EENTRY");
            end else begin
                write_csr({csr_pkg::CSR_SAVE0[13:2], pick[1:0]}, mask, data);
                save_model[pick[1:0]] = (data & mask) | (save_model[pick[1:0]] & ~mask);
                expect_csr({csr_pkg::CSR_SAVE0[13:2], pick[1:0]}, save_model[pick[1:0]],
                           "SAVE");
            end
        end
        finish_test(1, "reset and scratch writes");

        write_csr(csr_pkg::CSR_CRMD, 32'h7, 32'h7);
        pc    = $urandom;
        ecode = 6'($urandom);
        esub  = 9'($urandom);
        estat_codes = {1'b0, esub, ecode, 16'h0};
        raise_exception(1'b0);
        expect_csr(csr_pkg::CSR_CRMD, 32'h0, "CRMD after exception");
        expect_csr(csr_pkg::CSR_PRMD, 32'h7, "PRMD after exception");
        expect_csr(csr_pkg::CSR_ESTAT, estat_codes, "ESTAT codes");
        expect_csr(csr_pkg::CSR_ERA, pc, "ERA");
        assert (ex_entry == eentry_model) else begin
            $display("ERROR %0t: ex_entry %h, expected %h", $time, ex_entry, eentry_model);
            test_errors++;
        end
        finish_test(2, "exception entry");

        write_csr(csr_pkg::CSR_PRMD, 32'h7, 32'h6);
        return_from_exception();
        expect_csr(csr_pkg::CSR_CRMD, 32'h6, "CRMD after return");
        raise_exception(1'b1);
        expect_csr(csr_pkg::CSR_CRMD, 32'h0, "CRMD with write during exception");
        expect_csr(csr_pkg::CSR_PRMD, 32'h6, "PRMD with write during exception");
        finish_test(3, "exception return");

        // One-shot status bit rises 4N+1 edges after the load edge
        write_csr(csr_pkg::CSR_TCFG, '1, {30'(TIMER_N), 2'b01});
        csr_num <= csr_pkg::CSR_ESTAT;
        for (int j = 0; j <= 4 * TIMER_N + 6; j++) begin
            @(negedge clk);
            assert (csr_rvalue[csr_pkg::TIMER_INT_BIT] == (j >= 4 * TIMER_N + 1)) else begin
                $display("ERROR %0t: timer status %b at cycle %0d", $time,
                         csr_rvalue[csr_pkg::TIMER_INT_BIT], j);
                test_errors++;
            end
        end
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        expect_csr(csr_pkg::CSR_ESTAT, estat_codes, "ESTAT after TICLR");
        repeat (20) @(posedge clk);
        expect_csr(csr_pkg::CSR_ESTAT, estat_codes, "ESTAT after one-shot expiry");
        expect_csr(csr_pkg::CSR_TVAL, '1, "TVAL after one-shot expiry");
        finish_test(4, "one-shot timer");

        write_csr(csr_pkg::CSR_ECFG, '1, '1);
        expect_csr(csr_pkg::CSR_ECFG, 32'h1bff, "ECFG enables");
        write_csr(csr_pkg::CSR_CRMD, 32'h7, 32'h4);
        repeat (40) begin
            @(posedge clk);
            hw_int_in  <= ($urandom_range(1, 0) == 1) ? 8'($urandom) : 8'h0;
            ipi_int_in <= 1'($urandom);
        end
        @(posedge clk);
        hw_int_in  <= '0;
        ipi_int_in <= 1'b0;
        write_csr(csr_pkg::CSR_ESTAT, 32'h3, 32'h2);
        @(negedge clk);
        assert (has_int == 1'b1) else begin
            $display("ERROR %0t: has_int low with a software interrupt pending", $time);
            test_errors++;
        end
        write_csr(csr_pkg::CSR_ESTAT, 32'h3, 32'h0);
        write_csr(csr_pkg::CSR_TCFG, '1, {30'd2, 2'b11});
        repeat (3) begin
            repeat (8) @(posedge clk);
            write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        end
        write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
        repeat (10) @(posedge clk);
        write_csr(csr_pkg::CSR_TCFG, '1, '0);
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        finish_test(5, "interrupt request");

        $display("Tests run: 5, failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: csr_file.f
logic/csr_pkg.sv
logic/csr_access_decode.sv
logic/csr_exception_regs.sv
logic/csr_interrupt.sv
logic/csr_timer.sv
logic/csr_file_top.sv
tb/csr_file_checker.sv
tb/csr_file_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= csr_file.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qxF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
